/* all.f */
+incdir+include
rtl/mylstar_pkg.sv
rtl/clock_enables.sv
rtl/input_mapper.sv
rtl/spinner.sv
rtl/download_control.sv
rtl/audio_dac.sv
rtl/mylstar_io.sv
bench/tb_mylstar_io.sv

/* run.sh */
#!/bin/bash
# Compiles the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -Wno-fatal \
	-f all.f \
	--top-module tb_mylstar_io \
	-Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Test OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
	logic [6:0]  game;
	logic        diag;
	logic [15:0] p1;
	logic [15:0] p2;
	logic        svc;
	logic [7:0]  exp_1710;
	logic [7:0]  exp_4740;
} vec_t;

localparam int n_vec = 12;

// each row holds game, diagonal, p1, p2, service, expected ip1710 and expected ip4740
vec_t vec_table [n_vec] = '{
	'{qbert,    1'b0, 16'h0000, 16'h0000, 1'b0, 8'h40, 8'h00}, // idle with service line high
	'{qbert,    1'b0, 16'h1011, 16'h2008, 1'b1, 8'h86, 8'h41},
	'{qub,      1'b0, 16'h2006, 16'h1001, 1'b0, 8'h49, 8'h1A},
	'{qbert,    1'b1, 16'h0005, 16'h000A, 1'b0, 8'h40, 8'h21}, // diagonals
	'{qbert,    1'b1, 16'h0001, 16'h0006, 1'b0, 8'h40, 8'h80},
	'{mplanets, 1'b0, 16'h3031, 16'h1000, 1'b0, 8'hC3, 8'hB2},
	'{krull,    1'b0, 16'h1217, 16'h2008, 1'b1, 8'h86, 8'hE9}, // second stick merged
	'{curvebal, 1'b0, 16'h00C8, 16'h1000, 1'b0, 8'h09, 8'h52},
	'{argus,    1'b0, 16'h1030, 16'h0010, 1'b1, 8'h06, 8'h0B},
	'{kngtmare, 1'b0, 16'h2121, 16'h1002, 1'b0, 8'h08, 8'h6B},
	'{tylz,     1'b1, 16'h0019, 16'h2000, 1'b0, 8'h03, 8'h54},
	'{insector, 1'b0, 16'h0024, 16'h1010, 1'b0, 8'h5A, 8'h04}
};

`endif

/* bench/tb_mylstar_io.sv */
`timescale 1ns/10ps

module tb_mylstar_io;
	import mylstar_pkg::*;

	`include "tb_vectors.svh"

	localparam int clk_period = 40;
	localparam int n_random   = 32;
	localparam int n_writes   = 5;
	localparam int dac_len    = 256;
	// reset, enables, mapping, random mapping, download, spinners, dac, margin
	localparam int budget_cycles = 5 + 200 + 3 * n_vec + 3 * n_random + 150 + 100
		+ 5 * (dac_len + 8) + 500;

	logic        clk_sys = 1'b0;
	logic        rst_i;
	logic [15:0] p1_i, p2_i;
	logic        service_i, diagonal_i, vb_i, trackball_reset_i;
	game_t       game_i;
	logic        ioctl_downl_i, ioctl_wr_i, reset_req_i;
	logic [7:0]  ioctl_index_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  audio_i;
	logic [7:0]  ip1710_o, ip4740_o;
	logic [15:0] ipa1j2_o;
	logic        rom_init_o, nvram_init_o, port1_req_o, port2_req_o, core_reset_o;
	logic        cpu_clk_o, cen_5_o, cen_10p_o, cen_10n_o, sound_cen_o, audio_o;

	logic [16:0] lfsr_q = 17'd79886;
	logic [7:0]  dac_samples [5] = '{8'd0, 8'd1, 8'd128, 8'd255, 8'd77};
	logic        req1_q = 1'b0;
	logic        req2_q = 1'b0;
	int unsigned toggles_1 = 0;
	int unsigned toggles_2 = 0;

	mylstar_io #(.cpu_div(8), .sound_div(45), .dac_bits(8)) i_dut (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	// counts every change of the request toggles
	always @(negedge clk_sys) begin
		req1_q <= port1_req_o;
		req2_q <= port2_req_o;
		if (port1_req_o !== req1_q) toggles_1 <= toggles_1 + 1;
		if (port2_req_o !== req2_q) toggles_2 <= toggles_2 + 1;
	end

	initial begin
		#(budget_cycles * clk_period);
		$display("watchdog timeout: the tests did not finish within their cycle budget");
		$display("Test FAILED");
		$fatal(1);
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_plain(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
	endfunction

	task automatic random_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			bits   = {bits[14:0], lfsr_q[0]};
		end
	endtask

	// qbert layout with ip1710 in the upper byte and ip4740 in the lower
	function automatic logic [15:0] default_ports(input logic [15:0] a, input logic [15:0] b,
		input logic svc);
		logic [7:0] in1;
		logic [7:0] in4;
		in1    = 8'h00;
		in1[7] = a[joy_fire_a];
		in1[6] = !svc; // service is active low on the board
		in1[3] = b[joy_coin];
		in1[2] = a[joy_coin];
		in1[1] = b[joy_start];
		in1[0] = a[joy_start];
		in4 = {b[joy_down], b[joy_up], b[joy_left], b[joy_right],
			a[joy_down], a[joy_up], a[joy_left], a[joy_right]};
		return {in1, in4};
	endfunction

	task automatic write_pulse();
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b0;
		ioctl_addr_i <= ioctl_addr_i + 25'd1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic wait_core_reset(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (core_reset_o !== level) begin
			if (n == max_cycles) begin
				fail_plain(what);
			end else begin
				n++;
				@(negedge clk_sys);
			end
		end
	endtask

	task automatic vblank_frame();
		@(posedge clk_sys);
		vb_i <= 1'b1;
		@(posedge clk_sys);
		vb_i <= 1'b0;
		@(posedge clk_sys); // position then mapper register
		@(negedge clk_sys);
	endtask

	task automatic pulse_trackball_reset();
		@(posedge clk_sys);
		trackball_reset_i <= 1'b1;
		@(posedge clk_sys);
		trackball_reset_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	initial begin
		logic [15:0] rnd_a, rnd_b, rnd_s, exp_ports;
		logic [7:0]  planets_pos, track_x, track_y;
		int unsigned t1, t2;
		int          step, ones;

		rst_i = 1'b1;
		p1_i = '0;
		p2_i = '0;
		service_i = 1'b0;
		diagonal_i = 1'b0;
		game_i = qbert;
		vb_i = 1'b0;
		trackball_reset_i = 1'b0;
		ioctl_downl_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		reset_req_i = 1'b0;
		audio_i = 8'h00;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("cen_5_o", cen_5_o, 0);
		check("sound_cen_o", sound_cen_o, 0);
		check("core_reset_o", core_reset_o, 1);
		@(posedge clk_sys);
		rst_i <= 1'b0;

		// enable pattern counted from the release of reset
		for (int i = 1; i <= 200; i++) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("cen_5_o", cen_5_o, i % 8 == 0);
			check("cen_10p_o", cen_10p_o, i % 4 == 0);
			check("cen_10n_o", cen_10n_o, i % 4 == 2);
			check("cpu_clk_o", cpu_clk_o, (i - 1) % 8 >= 4);
			check("sound_cen_o", sound_cen_o, i % 45 == 0);
		end

		for (int i = 0; i < n_vec; i++) begin
			@(posedge clk_sys);
			game_i     <= game_t'(vec_table[i].game);
			diagonal_i <= vec_table[i].diag;
			p1_i       <= vec_table[i].p1;
			p2_i       <= vec_table[i].p2;
			service_i  <= vec_table[i].svc;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("ip1710_o", ip1710_o, vec_table[i].exp_1710);
			check("ip4740_o", ip4740_o, vec_table[i].exp_4740);
		end

		@(posedge clk_sys);
		game_i     <= qbert;
		diagonal_i <= 1'b0;
		for (int i = 0; i < n_random; i++) begin
			random_bits(16, rnd_a);
			random_bits(16, rnd_b);
			random_bits(1, rnd_s);
			@(posedge clk_sys);
			p1_i      <= rnd_a;
			p2_i      <= rnd_b;
			service_i <= rnd_s[0];
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp_ports = default_ports(rnd_a, rnd_b, rnd_s[0]);
			check("ip1710_o", ip1710_o, exp_ports[15:8]);
			check("ip4740_o", ip4740_o, exp_ports[7:0]);
		end

		@(posedge clk_sys);
		p1_i          <= '0;
		p2_i          <= '0;
		ioctl_index_i <= rom_index;
		ioctl_downl_i <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_init_o", rom_init_o, 1);
		check("nvram_init_o", nvram_init_o, 0);
		t1 = toggles_1;
		t2 = toggles_2;
		for (int i = 0; i < n_writes; i++) write_pulse();
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("port1_req_o toggles", toggles_1 - t1, n_writes);
		check("port2_req_o toggles", toggles_2 - t2, n_writes);
		check("core_reset_o", core_reset_o, 1); // not loaded yet
		@(posedge clk_sys);
		ioctl_downl_i <= 1'b0;
		wait_core_reset(1'b0, 8, "core reset stayed high after the ROM download ended");

		@(posedge clk_sys);
		ioctl_index_i <= nvram_index;
		ioctl_downl_i <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("nvram_init_o", nvram_init_o, 1);
		check("rom_init_o", rom_init_o, 0);
		t1 = toggles_1;
		t2 = toggles_2;
		for (int i = 0; i < 3; i++) write_pulse();
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("port1_req_o toggles", toggles_1 - t1, 0);
		check("port2_req_o toggles", toggles_2 - t2, 0);
		@(posedge clk_sys);
		ioctl_downl_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check("core_reset_o", core_reset_o, 0);

		@(posedge clk_sys);
		reset_req_i <= 1'b1;
		wait_core_reset(1'b1, 4, "core reset did not follow the reset request");
		@(posedge clk_sys);
		reset_req_i <= 1'b0;
		wait_core_reset(1'b0, 4, "core reset did not drop after the reset request");

		// mad planets spinner moves one count per frame
		planets_pos = 8'h00;
		@(posedge clk_sys);
		game_i <= mplanets;
		p1_i   <= 16'(1) << joy_fire_d;
		for (int i = 0; i < 3; i++) begin
			planets_pos = planets_pos + 8'd1;
			vblank_frame();
			check("ipa1j2_o", ipa1j2_o, {planets_pos, planets_pos});
		end
		@(posedge clk_sys);
		p1_i <= 16'(1) << joy_left_b;
		for (int i = 0; i < 5; i++) begin
			planets_pos = planets_pos - 8'd1;
			vblank_frame();
			check("ipa1j2_o", ipa1j2_o, {planets_pos, planets_pos});
		end

		@(posedge clk_sys);
		game_i <= argus;
		p1_i   <= '0;
		pulse_trackball_reset();
		check("ipa1j2_o", ipa1j2_o, 0);
		track_x = 8'h00;
		track_y = 8'h00;
		step    = 0;
		@(posedge clk_sys);
		p1_i <= 16'(1) << joy_right;
		for (int i = 0; i < 5; i++) begin
			step    = (step == 0) ? 1 : ((step == 8) ? 8 : step * 2);
			track_x = track_x + 8'(step);
			vblank_frame();
			check("ipa1j2_o", ipa1j2_o, {track_x, track_y});
		end
		step = 0;
		@(posedge clk_sys);
		p1_i <= 16'(1) << joy_down; // y counts up on down
		for (int i = 0; i < 2; i++) begin
			step    = (step == 0) ? 1 : step * 2;
			track_y = track_y + 8'(step);
			vblank_frame();
			check("ipa1j2_o", ipa1j2_o, {track_x, track_y});
		end
		pulse_trackball_reset();
		check("ipa1j2_o", ipa1j2_o, 0);

		foreach (dac_samples[k]) begin
			@(posedge clk_sys);
			audio_i <= dac_samples[k];
			repeat (3) @(posedge clk_sys);
			ones = 0;
			repeat (dac_len) begin
				@(negedge clk_sys);
				ones += int'(audio_o);
			end
			check("audio_o ones", ones, dac_samples[k]);
		end

		$display("Test OK");
		$finish;
	end

endmodule

/* rtl/mylstar_io.sv */
`timescale 1ns/10ps

module mylstar_io #(
	parameter int cpu_div   = 8,
	parameter int sound_div = 45,
	parameter int dac_bits  = 8
) (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic [mylstar_pkg::joy_w-1:0] p1_i,
	input  logic [mylstar_pkg::joy_w-1:0] p2_i,
	input  logic                          service_i,
	input  logic                          diagonal_i,
	input  mylstar_pkg::game_t            game_i,
	input  logic                          vb_i,
	input  logic                          trackball_reset_i,
	input  logic                          ioctl_downl_i,
	input  logic [7:0]                    ioctl_index_i,
	input  logic                          ioctl_wr_i,
	input  logic [24:0]                   ioctl_addr_i,
	input  logic                          reset_req_i,
	input  logic [dac_bits-1:0]           audio_i,
	output logic [7:0]                    ip1710_o,
	output logic [7:0]                    ip4740_o,
	output logic [15:0]                   ipa1j2_o,
	output logic                          rom_init_o,
	output logic                          nvram_init_o,
	output logic                          port1_req_o,
	output logic                          port2_req_o,
	output logic                          core_reset_o,
	output logic                          cpu_clk_o,
	output logic                          cen_5_o,
	output logic                          cen_10p_o,
	output logic                          cen_10n_o,
	output logic                          sound_cen_o,
	output logic                          audio_o
);
	import mylstar_pkg::*;

	logic             spin_rst;
	logic [pos_w-1:0] spin_pos;
	logic [pos_w-1:0] track_x;
	logic [pos_w-1:0] track_y;

	assign spin_rst = core_reset_o | trackball_reset_i;

	clock_enables #(.cpu_div(cpu_div), .sound_div(sound_div)) i_clock_enables (
		.clk_sys, .rst_i, .cpu_clk_o, .cen_5_o, .cen_10p_o, .cen_10n_o, .sound_cen_o
	);

	download_control i_download_control (
		.clk_sys, .rst_i, .ioctl_downl_i, .ioctl_index_i, .ioctl_wr_i, .reset_req_i,
		.rom_init_o, .nvram_init_o, .port1_req_o, .port2_req_o, .core_reset_o
	);

	// mad planets spinner on fire c/d or the second stick
	spinner #(.accel(1'b0)) i_spin_planets (
		.clk_sys, .rst_i(spin_rst), .vb_i,
		.left_i(p1_i[joy_fire_c] | p1_i[joy_left_b]),
		.right_i(p1_i[joy_fire_d] | p1_i[joy_right_b]),
		.pos_o(spin_pos)
	);

	spinner #(.accel(1'b1)) i_spin_x (
		.clk_sys, .rst_i(spin_rst), .vb_i,
		.left_i(p1_i[joy_left]), .right_i(p1_i[joy_right]), .pos_o(track_x)
	);

	spinner #(.accel(1'b1)) i_spin_y (
		.clk_sys, .rst_i(spin_rst), .vb_i,
		.left_i(p1_i[joy_up]), .right_i(p1_i[joy_down]), .pos_o(track_y)
	);

	input_mapper i_input_mapper (
		.clk_sys, .rst_i, .game_i, .p1_i, .p2_i, .service_i, .diagonal_i,
		.spin_i(spin_pos), .track_x_i(track_x), .track_y_i(track_y),
		.ip1710_o, .ip4740_o, .ipa1j2_o
	);

	audio_dac #(.dac_bits(dac_bits)) i_audio_dac (
		.clk_sys, .rst_i, .audio_i, .audio_o
	);

endmodule

/* rtl/audio_dac.sv */
`timescale 1ns/10ps

module audio_dac #(
	parameter int dac_bits = 8
) (
	input  logic                clk_sys,
	input  logic                rst_i,
	input  logic [dac_bits-1:0] audio_i,
	output logic                audio_o
);
	logic [dac_bits:0] acc; // top bit is the carry

	// first-order sigma-delta with the carry out as the bit stream
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[dac_bits-1:0]} + {1'b0, audio_i}; // carry dropped
		end
	end

	assign audio_o = acc[dac_bits];

endmodule

/* rtl/download_control.sv */
`timescale 1ns/10ps

module download_control (
	input  logic       clk_sys,
	input  logic       rst_i,
	input  logic       ioctl_downl_i,
	input  logic [7:0] ioctl_index_i,
	input  logic       ioctl_wr_i,
	input  logic       reset_req_i,
	output logic       rom_init_o,
	output logic       nvram_init_o,
	output logic       port1_req_o,
	output logic       port2_req_o,
	output logic       core_reset_o
);
	import mylstar_pkg::*;

	logic wr_q;
	logic wr_qq;
	logic downl_q;
	logic loaded; // sticky once the first download ends

	assign rom_init_o   = ioctl_downl_i && ioctl_index_i == rom_index;
	assign nvram_init_o = ioctl_downl_i && ioctl_index_i == nvram_index;

	// write strobes become toggle requests for both sdram ports
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_q        <= 1'b0;
			wr_qq       <= 1'b0;
			port1_req_o <= 1'b0;
			port2_req_o <= 1'b0;
		end else begin
			wr_q  <= ioctl_wr_i;
			wr_qq <= wr_q;
			if (rom_init_o && wr_q && !wr_qq) begin
				port1_req_o <= ~port1_req_o;
				port2_req_o <= ~port2_req_o;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			downl_q      <= 1'b0;
			loaded       <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			downl_q <= ioctl_downl_i;
			if (downl_q && !ioctl_downl_i) begin
				loaded <= 1'b1; // falling edge of downl
			end
			core_reset_o <= reset_req_i | ~loaded;
		end
	end

endmodule

/* rtl/spinner.sv */
`timescale 1ns/10ps

module spinner #(
	parameter bit accel = 1'b0
) (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic                          left_i,
	input  logic                          right_i,
	input  logic                          vb_i,
	output logic [mylstar_pkg::pos_w-1:0] pos_o
);
	import mylstar_pkg::*;

	logic       vb_d;
	logic       frame;
	logic       right_last; // direction of the previous move
	logic [3:0] step;       // last frame's step or 0 when idle
	logic [3:0] step_n;

	assign frame = vb_i & ~vb_d;

	always_comb begin
		step_n = 4'd0;
		if (left_i ^ right_i) begin
			if (accel && step != 4'd0 && right_last == right_i) begin
				step_n = (step == 4'd8) ? 4'd8 : step << 1; // doubles up to 8
			end else begin
				step_n = 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			vb_d       <= 1'b0;
			right_last <= 1'b0;
			step       <= 4'd0;
			pos_o      <= '0;
		end else begin
			vb_d <= vb_i;
			if (frame) begin
				step       <= step_n;
				right_last <= right_i;
				if (right_i) begin
					pos_o <= pos_o + pos_w'(step_n);
				end else begin
					pos_o <= pos_o - pos_w'(step_n); // wraps below zero
				end
			end
		end
	end

endmodule

/* rtl/input_mapper.sv */
`timescale 1ns/10ps

module input_mapper (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  mylstar_pkg::game_t            game_i,
	input  logic [mylstar_pkg::joy_w-1:0] p1_i,
	input  logic [mylstar_pkg::joy_w-1:0] p2_i,
	input  logic                          service_i,
	input  logic                          diagonal_i,
	input  logic [mylstar_pkg::pos_w-1:0] spin_i,
	input  logic [mylstar_pkg::pos_w-1:0] track_x_i,
	input  logic [mylstar_pkg::pos_w-1:0] track_y_i,
	output logic [7:0]                    ip1710_o,
	output logic [7:0]                    ip4740_o,
	output logic [15:0]                   ipa1j2_o
);
	import mylstar_pkg::*;

	logic [7:0]  in1;
	logic [7:0]  in4;
	logic [15:0] ina;

	always_comb begin
		in1 = {p1_i[joy_fire_a], ~service_i, 2'b00, p2_i[joy_coin], p1_i[joy_coin],
			p2_i[joy_start], p1_i[joy_start]};
		if (diagonal_i) begin
			// each line is the AND of two neighbouring directions
			in4 = {p2_i[joy_down] & p2_i[joy_left], p2_i[joy_up] & p2_i[joy_right],
				p2_i[joy_left] & p2_i[joy_up], p2_i[joy_right] & p2_i[joy_down],
				p1_i[joy_down] & p1_i[joy_left], p1_i[joy_up] & p1_i[joy_right],
				p1_i[joy_left] & p1_i[joy_up], p1_i[joy_right] & p1_i[joy_down]};
		end else begin
			in4 = {p2_i[joy_down], p2_i[joy_up], p2_i[joy_left], p2_i[joy_right],
				p1_i[joy_down], p1_i[joy_up], p1_i[joy_left], p1_i[joy_right]};
		end
		ina = '0;

		case (game_i)
			mplanets: begin
				in1 = {~service_i, p1_i[joy_fire_a], 4'd0, p2_i[joy_coin], p1_i[joy_coin]};
				in4 = {p1_i[joy_fire_b], p2_i[joy_start], p1_i[joy_start], p1_i[joy_fire_a],
					p1_i[joy_left], p1_i[joy_down], p1_i[joy_right], p1_i[joy_up]};
				ina = {spin_i, spin_i};
			end
			krull: begin
				in1 = {p2_i[joy_start], p1_i[joy_start], 2'b00, p2_i[joy_coin],
					p1_i[joy_coin], p1_i[joy_fire_a], ~service_i};
				// right stick comes from player 2 or the second stick of player 1
				in4 = {p1_i[joy_left], p1_i[joy_down], p1_i[joy_right], p1_i[joy_up],
					p2_i[joy_left] | p1_i[joy_left_b], p2_i[joy_down] | p1_i[joy_down_b],
					p2_i[joy_right] | p1_i[joy_right_b], p2_i[joy_up] | p1_i[joy_up_b]};
			end
			curvebal: begin
				in1 = {4'd0, p2_i[joy_coin], p1_i[joy_coin], p1_i[joy_fire_a], ~service_i};
				in4 = {1'b0, p1_i[joy_fire_d] | p1_i[joy_down], // bunt
					1'b0, p1_i[joy_fire_c] | p1_i[joy_right],     // pitch right
					1'b0, p1_i[joy_fire_b] | p1_i[joy_left],      // pitch left
					p1_i[joy_fire_a] | p1_i[joy_up], 1'b0};        // swing
			end
			tylz: begin
				in1 = {4'd0, p1_i[joy_coin], p2_i[joy_coin], p1_i[joy_fire_a], ~service_i};
				in4 = {1'b0, p2_i[joy_start], p1_i[joy_start], p1_i[joy_fire_a],
					diagonal_i ? p1_i[joy_left] & p1_i[joy_up] : p1_i[joy_left],
					diagonal_i ? p1_i[joy_right] & p1_i[joy_up] : p1_i[joy_up],
					diagonal_i ? p1_i[joy_right] & p1_i[joy_down] : p1_i[joy_right],
					diagonal_i ? p1_i[joy_left] & p1_i[joy_down] : p1_i[joy_down]};
			end
			insector: begin
				in1 = {1'b0, ~service_i, p2_i[joy_fire_b], p2_i[joy_fire_a],
					p2_i[joy_coin], p1_i[joy_coin], p1_i[joy_fire_b], p1_i[joy_fire_a]};
				in4 = {p2_i[joy_left], p2_i[joy_down], p2_i[joy_right], p2_i[joy_up],
					p1_i[joy_left], p1_i[joy_down], p1_i[joy_right], p1_i[joy_up]};
			end
			argus: begin
				in1 = {4'h0, p2_i[joy_coin], p1_i[joy_coin], p1_i[joy_fire_a], ~service_i};
				in4 = {4'h0, p2_i[joy_fire_a], p2_i[joy_fire_b],
					p1_i[joy_fire_a], p1_i[joy_fire_b]};
				ina = {track_x_i, track_y_i}; // x high, y low
			end
			kngtmare: begin
				in1 = {4'h0, p2_i[joy_coin], p1_i[joy_coin], 2'b00};
				in4 = {p2_i[joy_start], p1_i[joy_start], p1_i[joy_fire_b], p1_i[joy_fire_a],
					p1_i[joy_right_b] | p2_i[joy_right], p1_i[joy_left],
					p1_i[joy_left_b] | p2_i[joy_left], p1_i[joy_right]};
			end
			default: begin
				ina = '0; // qbert and qub use the plain layout
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			ip1710_o <= '0;
			ip4740_o <= '0;
			ipa1j2_o <= '0;
		end else begin
			ip1710_o <= in1;
			ip4740_o <= in4;
			ipa1j2_o <= ina;
		end
	end

endmodule

/* rtl/clock_enables.sv */
`timescale 1ns/10ps

module clock_enables #(
	parameter int cpu_div   = 8,
	parameter int sound_div = 45
) (
	input  logic clk_sys,
	input  logic rst_i,
	output logic cpu_clk_o,
	output logic cen_5_o,
	output logic cen_10p_o,
	output logic cen_10n_o,
	output logic sound_cen_o
);
	localparam int cw = $clog2(cpu_div);
	localparam int sw = $clog2(sound_div);

	logic [cw-1:0] cnt;
	logic [sw-1:0] snd_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			cnt         <= '0;
			cpu_clk_o   <= 1'b0;
			cen_5_o     <= 1'b0;
			cen_10p_o   <= 1'b0;
			cen_10n_o   <= 1'b0;
		end else begin
			cnt       <= (cnt == cw'(cpu_div - 1)) ? '0 : cnt + 1'b1;
			cpu_clk_o <= cnt[cw-1]; // top bit is the cpu clock
			cen_5_o   <= cnt == cw'(cpu_div - 1);
			cen_10p_o <= cnt == cw'(cpu_div / 2 - 1) || cnt == cw'(cpu_div - 1);
			cen_10n_o <= cnt == cw'(cpu_div / 4 - 1) || cnt == cw'(3 * cpu_div / 4 - 1);
		end
	end

	// sound board enable
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			snd_cnt     <= '0;
			sound_cen_o <= 1'b0;
		end else begin
			snd_cnt     <= (snd_cnt == sw'(sound_div - 1)) ? '0 : snd_cnt + 1'b1;
			sound_cen_o <= snd_cnt == sw'(sound_div - 1);
		end
	end

endmodule

/* rtl/mylstar_pkg.sv */
package mylstar_pkg;

	// game number as reported by the core_mod field
	typedef enum logic [6:0] {
		qbert    = 7'd0,
		qub      = 7'd1,
		mplanets = 7'd2,
		krull    = 7'd3,
		curvebal = 7'd4,
		tylz     = 7'd5,
		insector = 7'd6,
		argus    = 7'd7,
		kngtmare = 7'd8
	} game_t;

	localparam int joy_w = 16; // one player control word

	// main stick
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;

	localparam int joy_fire_a = 4;
	localparam int joy_fire_b = 5;
	localparam int joy_fire_c = 6;
	localparam int joy_fire_d = 7;

	// second stick
	localparam int joy_right_b = 8;
	localparam int joy_left_b  = 9;
	localparam int joy_down_b  = 10;
	localparam int joy_up_b    = 11;

	localparam int joy_coin  = 12;
	localparam int joy_start = 13;

	// ioctl download kinds
	localparam logic [7:0] rom_index   = 8'h00;
	localparam logic [7:0] nvram_index = 8'hFF;

	localparam int pos_w = 8; // spinner position

endpackage
